//--- verilog/dma_pkg.sv
// Shared DMA widths and encodings; addresses count words, memory depth fixed at 1024
package dma_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////
	localparam int WORD_W = 32;
	localparam int ADDR_W = 16;
	localparam int LEN_W = 16;
	localparam int MEM_AW = 10;
	localparam int MEM_WORDS = 1024;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LEN_W-1:0] len_t;
	typedef logic [1:0] reg_addr_t;
	typedef logic [MEM_AW-1:0] mem_addr_t;

	////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////
	localparam reg_addr_t REG_CTRL = 2'd0;
	localparam reg_addr_t REG_SRC = 2'd1;
	localparam reg_addr_t REG_DST = 2'd2;
	localparam reg_addr_t REG_LEN = 2'd3;

	// "ABRT" in ASCII
	localparam word_t ABORT_KEY = 32'h41425254;

	// Control word bit positions
	localparam int CTRL_BUSY = 31;
	localparam int CTRL_ERR = 30;
	localparam int CTRL_INT = 29;
	localparam int CTRL_DST_FIXED = 22;
	localparam int CTRL_SRC_FIXED = 18;

	// Mover FSM
	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE,
		DONE
	} mover_state_t;

endpackage

//--- verilog/dma_ctrl_if.sv
// Register file to mover link; request and abort are levels held until busy drops
`timescale 1ns/1ps

interface dma_ctrl_if;
	import dma_pkg::*;

	// Set up by the register file
	logic	request;
	logic	abort;
	addr_t	src;
	addr_t	dst;
	len_t	len;
	logic	src_inc;
	logic	dst_inc;

	// Returned by the mover
	logic	busy;
	logic	err;
	addr_t	cur_src;
	addr_t	cur_dst;
	len_t	remaining;

	modport ctrl (
		output request, abort, src, dst, len, src_inc, dst_inc,
		input busy, err, cur_src, cur_dst, remaining
	);

	modport mover (
		input request, abort, src, dst, len, src_inc, dst_inc,
		output busy, err, cur_src, cur_dst, remaining
	);

endinterface

//--- verilog/dma_regs.sv
// Control port, never stalls; setup writes ignored while request or busy is high
`timescale 1ns/1ps

module dma_regs (
	input	logic			i_clk,
	input	logic			i_reset,
	input	logic			i_stb,
	input	logic			i_we,
	input	dma_pkg::reg_addr_t	i_addr,
	input	dma_pkg::word_t		i_data,
	input	logic	[3:0]		i_sel,
	output	logic			o_ack,
	output	dma_pkg::word_t		o_data,
	output	logic			o_interrupt,
	dma_ctrl_if.ctrl		ctrl
);
	import dma_pkg::*;

	addr_t	r_src;
	addr_t	r_dst;
	len_t	r_len;
	logic	r_src_fixed;
	logic	r_dst_fixed;
	logic	r_err;
	logic	r_busy;
	logic	ctrl_wr;
	logic	idle_wr;
	word_t	ctrl_word;
	addr_t	next_src;
	addr_t	next_dst;
	len_t	next_len;

	// Low two byte lanes merged over a 16 bit register
	function automatic addr_t merge_lo(input addr_t old, input word_t data,
			input logic [1:0] sel);
		addr_t	v;
		v = old;
		if (sel[0])
			v[7:0] = data[7:0];
		if (sel[1])
			v[15:8] = data[15:8];
		return v;
	endfunction

	assign ctrl_wr = i_stb && i_we && (i_addr == REG_CTRL);
	// Setup writes only land while nothing is pending
	assign idle_wr = i_stb && i_we && !ctrl.request && !ctrl.busy;

	assign next_src = merge_lo(r_src, i_data, i_sel[1:0]);
	assign next_dst = merge_lo(r_dst, i_data, i_sel[1:0]);
	assign next_len = len_t'(merge_lo(addr_t'(r_len), i_data, i_sel[1:0]));

	assign ctrl.src = r_src;
	assign ctrl.dst = r_dst;
	assign ctrl.len = r_len;
	// Stored as fixed flags so reset means incrementing
	assign ctrl.src_inc = !r_src_fixed;
	assign ctrl.dst_inc = !r_dst_fixed;

	////////////////////////////////////////////////////////////
	// Bus response
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
		if (i_reset)
			o_ack <= 1'b0;
		else
			o_ack <= i_stb;

	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[CTRL_BUSY] = ctrl.busy;
		// Error shows as soon as the mover flags it
		ctrl_word[CTRL_ERR] = r_err || ctrl.err;
		ctrl_word[CTRL_INT] = o_interrupt;
		ctrl_word[CTRL_DST_FIXED] = r_dst_fixed;
		ctrl_word[CTRL_SRC_FIXED] = r_src_fixed;
	end

	// Live mover values while busy, stored ones otherwise
	always_ff @(posedge i_clk)
		if (i_stb)
		begin
			case (i_addr)
				REG_CTRL: o_data <= ctrl_word;
				REG_SRC: o_data <= {16'h0, ctrl.busy ? ctrl.cur_src : r_src};
				REG_DST: o_data <= {16'h0, ctrl.busy ? ctrl.cur_dst : r_dst};
				default: o_data <= {16'h0, ctrl.busy ? ctrl.remaining : r_len};
			endcase
		end

	////////////////////////////////////////////////////////////
	// Setup registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			r_src <= '0;
			r_dst <= '0;
			r_len <= '0;
			r_src_fixed <= 1'b0;
			r_dst_fixed <= 1'b0;
		end
		else if (ctrl.busy)
		begin
			// Track the mover, so the end state holds the next addresses
			r_src <= ctrl.cur_src;
			r_dst <= ctrl.cur_dst;
			r_len <= ctrl.remaining;
		end
		else if (idle_wr)
		begin
			case (i_addr)
				REG_CTRL:
				begin
					if (i_sel[2])
					begin
						r_dst_fixed <= i_data[CTRL_DST_FIXED];
						r_src_fixed <= i_data[CTRL_SRC_FIXED];
					end
				end
				REG_SRC: r_src <= next_src;
				REG_DST: r_dst <= next_dst;
				default: r_len <= next_len;
			endcase
		end

	////////////////////////////////////////////////////////////
	// Start, abort, error and interrupt
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			ctrl.request <= 1'b0;
			ctrl.abort <= 1'b0;
			r_err <= 1'b0;
			r_busy <= 1'b0;
			o_interrupt <= 1'b0;
		end
		else
		begin
			r_busy <= ctrl.busy;

			// Falling busy ends the transfer, however it ended
			if (r_busy && !ctrl.busy)
			begin
				ctrl.request <= 1'b0;
				ctrl.abort <= 1'b0;
				o_interrupt <= 1'b1;
			end

			// Sticky until cleared by bit 30
			if (ctrl.err)
				r_err <= 1'b1;

			if (ctrl_wr)
			begin
				if (ctrl.request || ctrl.busy)
				begin
					// Abort only once the mover has taken the request
					if (ctrl.busy && (&i_sel) && (i_data == ABORT_KEY))
					begin
						ctrl.request <= 1'b0;
						ctrl.abort <= 1'b1;
					end
				end
				else if (i_sel[3])
				begin
					if (i_data[CTRL_INT] || !i_data[CTRL_ERR])
						o_interrupt <= 1'b0;
					if (i_data[CTRL_ERR])
						r_err <= 1'b0;
					// Refused while an error is left uncleared
					if (!i_data[CTRL_BUSY] && (!r_err || i_data[CTRL_ERR]))
						ctrl.request <= (r_len != '0);
				end
			end
		end

	// Never both pending at once
	a_req_abort: assert property (@(posedge i_clk) disable iff (i_reset)
		!(ctrl.request && ctrl.abort));

	// Interrupt rises only on the cycle after busy falls
	a_int_after_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		$rose(o_interrupt) |-> !ctrl.busy && !$past(ctrl.busy) && $past(ctrl.busy, 2));

endmodule

//--- verilog/dma_mover.sv
// Word copier, two cycles per word; expects a nonzero length from the register file
`timescale 1ns/1ps

module dma_mover (
	input	logic			i_clk,
	input	logic			i_reset,
	dma_ctrl_if.mover		ctrl,
	output	logic			o_rd_en,
	output	dma_pkg::mem_addr_t	o_rd_addr,
	input	dma_pkg::word_t		i_rd_data,
	output	logic			o_wr_en,
	output	dma_pkg::mem_addr_t	o_wr_addr,
	output	dma_pkg::word_t		o_wr_data
);
	import dma_pkg::*;

	mover_state_t	state;
	// Blocks a restart while the request level is still up
	logic		req_taken;
	logic		in_range;
	addr_t		src_step;
	addr_t		dst_step;

	assign src_step = {{(ADDR_W-1){1'b0}}, ctrl.src_inc};
	assign dst_step = {{(ADDR_W-1){1'b0}}, ctrl.dst_inc};

	// Both ends of the current word must sit inside the memory
	assign in_range = (ctrl.cur_src < addr_t'(MEM_WORDS))
		&& (ctrl.cur_dst < addr_t'(MEM_WORDS));

	////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////
	assign o_rd_en = (state == READ) && in_range;
	assign o_rd_addr = ctrl.cur_src[MEM_AW-1:0];

	// Read data lands in the WRITE cycle
	assign o_wr_en = (state == WRITE);
	assign o_wr_addr = ctrl.cur_dst[MEM_AW-1:0];
	assign o_wr_data = i_rd_data;

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			state <= IDLE;
			req_taken <= 1'b0;
			ctrl.busy <= 1'b0;
			ctrl.err <= 1'b0;
			ctrl.cur_src <= '0;
			ctrl.cur_dst <= '0;
			ctrl.remaining <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (ctrl.request && !req_taken)
					begin
						// Load the job, busy from the next cycle
						ctrl.cur_src <= ctrl.src;
						ctrl.cur_dst <= ctrl.dst;
						ctrl.remaining <= ctrl.len;
						ctrl.busy <= 1'b1;
						req_taken <= 1'b1;
						state <= READ;
					end
					else if (!ctrl.request)
						req_taken <= 1'b0;
				end
				READ:
				begin
					// Out of range word is skipped, not copied
					if (!in_range)
					begin
						ctrl.err <= 1'b1;
						state <= DONE;
					end
					else
						state <= WRITE;
				end
				WRITE:
				begin
					ctrl.cur_src <= ctrl.cur_src + src_step;
					ctrl.cur_dst <= ctrl.cur_dst + dst_step;
					ctrl.remaining <= ctrl.remaining - len_t'(1);
					// Abort waits for this write to finish
					if ((ctrl.remaining == len_t'(1)) || ctrl.abort)
						state <= DONE;
					else
						state <= READ;
				end
				DONE:
				begin
					// err only lives for the DONE cycle
					ctrl.busy <= 1'b0;
					ctrl.err <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end

	// Every write belongs to a counted word of a running transfer
	a_wr_counted: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wr_en |-> ctrl.busy && (ctrl.remaining != '0));

	// busy covers all of a transfer
	a_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		(state != IDLE) |-> ctrl.busy);

endmodule

//--- verilog/dma_sram.sv
// Two port word memory, one cycle reads, no reset of contents; B wins a write clash
`timescale 1ns/1ps

module dma_sram (
	input	logic			i_clk,
	// External side
	input	logic			i_a_we,
	input	logic			i_a_re,
	input	dma_pkg::mem_addr_t	i_a_addr,
	input	dma_pkg::word_t		i_a_wdata,
	output	dma_pkg::word_t		o_a_rdata,
	// Mover side
	input	logic			i_b_re,
	input	dma_pkg::mem_addr_t	i_b_raddr,
	output	dma_pkg::word_t		o_b_rdata,
	input	logic			i_b_we,
	input	dma_pkg::mem_addr_t	i_b_waddr,
	input	dma_pkg::word_t		i_b_wdata
);
	import dma_pkg::*;

	word_t	mem [MEM_WORDS];

	////////////////////////////////////////////////////////////
	// Writes
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_a_we && !(i_b_we && (i_b_waddr == i_a_addr)))
			mem[i_a_addr] <= i_a_wdata;
		// Mover port has priority on the same word
		if (i_b_we)
			mem[i_b_waddr] <= i_b_wdata;
	end

	// Registered reads, old data on a same cycle write
	always_ff @(posedge i_clk)
		if (i_a_re)
			o_a_rdata <= mem[i_a_addr];

	always_ff @(posedge i_clk)
		if (i_b_re)
			o_b_rdata <= mem[i_b_raddr];

endmodule

//--- verilog/dma_top.sv
// DMA top; external memory port is meant for use only while the DMA is stopped
`timescale 1ns/1ps

module dma_top (
	input	logic			i_clk,
	input	logic			i_reset,
	// Control bus
	input	logic			i_stb,
	input	logic			i_we,
	input	dma_pkg::reg_addr_t	i_addr,
	input	dma_pkg::word_t		i_data,
	input	logic	[3:0]		i_sel,
	output	logic			o_ack,
	output	dma_pkg::word_t		o_data,
	output	logic			o_interrupt,
	// External memory access
	input	logic			i_mem_we,
	input	logic			i_mem_re,
	input	dma_pkg::mem_addr_t	i_mem_addr,
	input	dma_pkg::word_t		i_mem_wdata,
	output	dma_pkg::word_t		o_mem_rdata
);
	import dma_pkg::*;

	dma_ctrl_if	u_ctrl_if ();

	// Mover to memory
	logic		rd_en;
	mem_addr_t	rd_addr;
	word_t		rd_data;
	logic		wr_en;
	mem_addr_t	wr_addr;
	word_t		wr_data;

	dma_regs u_regs (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_stb		(i_stb),
		.i_we		(i_we),
		.i_addr		(i_addr),
		.i_data		(i_data),
		.i_sel		(i_sel),
		.o_ack		(o_ack),
		.o_data		(o_data),
		.o_interrupt	(o_interrupt),
		.ctrl		(u_ctrl_if.ctrl)
	);

	dma_mover u_mover (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.ctrl		(u_ctrl_if.mover),
		.o_rd_en	(rd_en),
		.o_rd_addr	(rd_addr),
		.i_rd_data	(rd_data),
		.o_wr_en	(wr_en),
		.o_wr_addr	(wr_addr),
		.o_wr_data	(wr_data)
	);

	dma_sram u_sram (
		.i_clk		(i_clk),
		.i_a_we		(i_mem_we),
		.i_a_re		(i_mem_re),
		.i_a_addr	(i_mem_addr),
		.i_a_wdata	(i_mem_wdata),
		.o_a_rdata	(o_mem_rdata),
		.i_b_re		(rd_en),
		.i_b_raddr	(rd_addr),
		.o_b_rdata	(rd_data),
		.i_b_we		(wr_en),
		.i_b_waddr	(wr_addr),
		.i_b_wdata	(wr_data)
	);

endmodule

//--- bench/dma_tb.sv
// DMA testbench; random data from a fixed seed, memory checked against a model array
`timescale 1ns/1ps

module dma_tb;
	import dma_pkg::*;

	// Budget per transfer is 2*len+10 plus bus and compare traffic
	localparam int XFER_COUNT = 28;
	localparam int LEN_SUM = 20 * 32 + 2 * 16 + 3 * 16 + 200 + 16;
	localparam int TEST_BOUND = MEM_WORDS + 200 + XFER_COUNT * 40 + LEN_SUM * 4;
	localparam int CYCLE_LIMIT = 2 * TEST_BOUND;

	logic		i_clk;
	logic		i_reset;
	logic		i_stb;
	logic		i_we;
	reg_addr_t	i_addr;
	word_t		i_data;
	logic	[3:0]	i_sel;
	logic		o_ack;
	word_t		o_data;
	logic		o_interrupt;
	logic		i_mem_we;
	logic		i_mem_re;
	mem_addr_t	i_mem_addr;
	word_t		i_mem_wdata;
	word_t		o_mem_rdata;

	// Mirror of the DUT memory
	word_t		model [MEM_WORDS];
	int		cycle_count = 0;
	int		err_count = 0;
	int		test_count = 0;
	int		fail_count = 0;
	int		test_base = 0;

	dma_top u_dut (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_stb		(i_stb),
		.i_we		(i_we),
		.i_addr		(i_addr),
		.i_data		(i_data),
		.i_sel		(i_sel),
		.o_ack		(o_ack),
		.o_data		(o_data),
		.o_interrupt	(o_interrupt),
		.i_mem_we	(i_mem_we),
		.i_mem_re	(i_mem_re),
		.i_mem_addr	(i_mem_addr),
		.i_mem_wdata	(i_mem_wdata),
		.o_mem_rdata	(o_mem_rdata)
	);

	always #4 i_clk = ~i_clk;

	// Run limit
	always @(posedge i_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("run stopped: no result after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and reference rules
	////////////////////////////////////////////////////////////
	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
			err_count++;
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (err_count == test_base)
			$display("test %0d %s: passed", test_count, name);
		else
		begin
			fail_count++;
			$display("test %0d %s: failed, %0d errors", test_count, name, err_count - test_base);
		end
		test_base = err_count;
	endtask

	// Only lanes 0 and 1 reach a 16 bit register
	function automatic word_t merge_lanes(input word_t old, input word_t data,
			input logic [3:0] sel);
		word_t	v;
		v = old;
		if (sel[0])
			v[7:0] = data[7:0];
		if (sel[1])
			v[15:8] = data[15:8];
		v[31:16] = '0;
		return v;
	endfunction

	// Same positions for the written command and the read status
	function automatic word_t pack_ctrl(input bit b31, input bit b30, input bit b29,
			input bit src_fix, input bit dst_fix);
		word_t	w;
		w = '0;
		w[CTRL_BUSY] = b31;
		w[CTRL_ERR] = b30;
		w[CTRL_INT] = b29;
		w[CTRL_SRC_FIXED] = src_fix;
		w[CTRL_DST_FIXED] = dst_fix;
		return w;
	endfunction

	// Word by word copy, stops at the first out of range word
	task automatic model_copy(input int src, input int dst, input int len, input bit src_fix,
			input bit dst_fix, output int done, output bit range_err,
			output int end_src, output int end_dst);
		int	s;
		int	d;
		s = src;
		d = dst;
		done = 0;
		range_err = 1'b0;
		while (done < len && !range_err)
		begin
			if (s >= MEM_WORDS || d >= MEM_WORDS)
				range_err = 1'b1;
			else
			begin
				model[mem_addr_t'(d)] = model[mem_addr_t'(s)];
				if (!src_fix)
					s++;
				if (!dst_fix)
					d++;
				done++;
			end
		end
		end_src = s;
		end_dst = d;
	endtask

	////////////////////////////////////////////////////////////
	// Bus and memory access
	////////////////////////////////////////////////////////////
	task automatic bus_access(input logic we, input reg_addr_t addr, input word_t data,
			input logic [3:0] sel, output word_t rdata);
		@(posedge i_clk);
		i_stb <= 1'b1;
		i_we <= we;
		i_addr <= addr;
		i_data <= data;
		i_sel <= sel;
		@(posedge i_clk);
		i_stb <= 1'b0;
		i_we <= 1'b0;
		// Ack and data settle in the cycle after the strobe
		@(negedge i_clk);
		if (o_ack !== 1'b1)
		begin
			$display("bus access to register %0d got no ack at %0t", addr, $time);
			err_count++;
		end
		rdata = o_data;
	endtask

	task automatic bus_write(input reg_addr_t addr, input word_t data, input logic [3:0] sel);
		word_t	unused;
		bus_access(1'b1, addr, data, sel, unused);
	endtask

	task automatic bus_read(input reg_addr_t addr, output word_t data);
		bus_access(1'b0, addr, '0, 4'b0000, data);
	endtask

	task automatic mem_read(input int a, output word_t data);
		@(posedge i_clk);
		i_mem_re <= 1'b1;
		i_mem_addr <= mem_addr_t'(a);
		@(posedge i_clk);
		i_mem_re <= 1'b0;
		@(negedge i_clk);
		data = o_mem_rdata;
	endtask

	task automatic compare_range(input int start, input int count);
		word_t	got;
		int	a;
		for (int i = 0; i < count; i++)
		begin
			a = start + i;
			if (a < MEM_WORDS)
			begin
				mem_read(a, got);
				check_word($sformatf("o_mem_rdata[%0d]", a), got, model[mem_addr_t'(a)]);
			end
		end
	endtask

	task automatic wait_irq(input int bound, output bit seen);
		int	n;
		n = 0;
		seen = 1'b0;
		while (n < bound && !seen)
		begin
			@(negedge i_clk);
			seen = (o_interrupt === 1'b1);
			n++;
		end
	endtask

	task automatic setup_copy(input int src, input int dst, input int len);
		bus_write(REG_SRC, word_t'(src), 4'b0011);
		bus_write(REG_DST, word_t'(dst), 4'b0011);
		bus_write(REG_LEN, word_t'(len), 4'b0011);
	endtask

	// Full copy with error clear, then status, registers and memory
	task automatic run_copy(input int src, input int dst, input int len, input bit src_fix,
			input bit dst_fix);
		int	done;
		bit	range_err;
		int	end_src;
		int	end_dst;
		bit	seen;
		word_t	rd;
		setup_copy(src, dst, len);
		bus_write(REG_CTRL, pack_ctrl(1'b0, 1'b1, 1'b1, src_fix, dst_fix), 4'b1111);
		wait_irq(2 * len + 10, seen);
		if (!seen)
		begin
			$display("copy %0d to %0d: interrupt never rose", src, dst);
			err_count++;
		end
		model_copy(src, dst, len, src_fix, dst_fix, done, range_err, end_src, end_dst);
		bus_read(REG_CTRL, rd);
		check_word("o_data CTRL", rd, pack_ctrl(1'b0, range_err, 1'b1, src_fix, dst_fix));
		bus_read(REG_SRC, rd);
		check_word("o_data SRC", rd, word_t'(end_src));
		bus_read(REG_DST, rd);
		check_word("o_data DST", rd, word_t'(end_dst));
		bus_read(REG_LEN, rd);
		check_word("o_data LEN", rd, word_t'(len - done));
		compare_range(dst, len);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		word_t	d;
		word_t	rd;
		word_t	exp_reg [4];
		logic	[3:0] sel;
		bit	sfix;
		bit	dfix;
		bit	seen;
		int	len;
		int	src;
		int	dst;
		int	done;
		bit	range_err;
		int	end_src;
		int	end_dst;

		i_clk = 1'b0;
		i_reset = 1'b1;
		i_stb = 1'b0;
		i_we = 1'b0;
		i_addr = '0;
		i_data = '0;
		i_sel = '0;
		i_mem_we = 1'b0;
		i_mem_re = 1'b0;
		i_mem_addr = '0;
		i_mem_wdata = '0;
		void'($urandom(32'h9654));
		repeat (3) @(posedge i_clk);
		i_reset <= 1'b0;

		// Fill the memory and the model
		for (int a = 0; a < MEM_WORDS; a++)
		begin
			@(posedge i_clk);
			d = $urandom;
			model[mem_addr_t'(a)] = d;
			i_mem_we <= 1'b1;
			i_mem_addr <= mem_addr_t'(a);
			i_mem_wdata <= d;
		end
		@(posedge i_clk);
		i_mem_we <= 1'b0;

		// 1: lane merged readback while idle
		exp_reg[REG_SRC] = '0;
		exp_reg[REG_DST] = '0;
		exp_reg[REG_LEN] = '0;
		sfix = 1'b0;
		dfix = 1'b0;
		for (int i = 0; i < 8; i++)
		begin
			for (int r = 1; r < 4; r++)
			begin
				d = $urandom;
				sel = 4'($urandom);
				bus_write(reg_addr_t'(r), d, sel);
				exp_reg[r] = merge_lanes(exp_reg[r], d, sel);
				bus_read(reg_addr_t'(r), rd);
				check_word($sformatf("o_data reg %0d", r), rd, exp_reg[r]);
			end
			// Bit 31 set keeps it from starting
			d = $urandom | 32'h8000_0000;
			sel = 4'($urandom);
			bus_write(REG_CTRL, d, sel);
			if (sel[2])
			begin
				sfix = d[CTRL_SRC_FIXED];
				dfix = d[CTRL_DST_FIXED];
			end
			bus_read(REG_CTRL, rd);
			check_word("o_data CTRL", rd, pack_ctrl(1'b0, 1'b0, 1'b0, sfix, dfix));
		end
		bus_write(REG_CTRL, '0, 4'b0100);
		end_test("register readback");

		// 2: random incrementing copies
		for (int i = 0; i < 20; i++)
		begin
			len = 1 + int'($urandom % 32);
			src = int'($urandom % (MEM_WORDS - len + 1));
			dst = int'($urandom % (MEM_WORDS - len + 1));
			run_copy(src, dst, len, 1'b0, 1'b0);
		end
		end_test("incrementing copies");

		// 3: fixed source, then fixed destination
		run_copy(int'($urandom % 1000), int'($urandom % 1000), 16, 1'b1, 1'b0);
		run_copy(int'($urandom % 1000), int'($urandom % 1000), 16, 1'b0, 1'b1);
		end_test("fixed addresses");

		// 4: copy runs off the end after 5 words
		run_copy(50, MEM_WORDS - 5, 12, 1'b0, 1'b0);
		setup_copy(10, 300, 16);
		bus_write(REG_CTRL, pack_ctrl(1'b0, 1'b0, 1'b1, 1'b0, 1'b0), 4'b1111);
		wait_irq(2 * 16 + 10, seen);
		if (seen)
		begin
			$display("start with an uncleared error raised the interrupt");
			err_count++;
		end
		bus_read(REG_CTRL, rd);
		check_word("o_data CTRL", rd, pack_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		compare_range(300, 16);
		run_copy(10, 300, 16, 1'b0, 1'b0);
		end_test("range error");

		// 5: abort a long copy, busy writes ignored
		setup_copy(100, 600, 200);
		bus_write(REG_CTRL, pack_ctrl(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), 4'b1111);
		repeat (20) @(posedge i_clk);
		bus_write(REG_SRC, 32'h0000_0abc, 4'b0011);
		// Fixed flags must not change under a running copy
		bus_write(REG_CTRL, pack_ctrl(1'b0, 1'b0, 1'b0, 1'b1, 1'b1), 4'b0100);
		bus_write(REG_CTRL, ABORT_KEY, 4'b1111);
		wait_irq(2 * 200 + 10, seen);
		if (!seen)
		begin
			$display("aborted copy never raised the interrupt");
			err_count++;
		end
		bus_read(REG_LEN, rd);
		if (rd == 0 || rd >= 200)
		begin
			$display("abort did not end the copy early, %0d words left", rd);
			err_count++;
		end
		model_copy(100, 600, 200 - int'(rd[15:0]), 1'b0, 1'b0, done, range_err,
			end_src, end_dst);
		bus_read(REG_SRC, rd);
		check_word("o_data SRC", rd, word_t'(end_src));
		bus_read(REG_DST, rd);
		check_word("o_data DST", rd, word_t'(end_dst));
		bus_read(REG_CTRL, rd);
		check_word("o_data CTRL", rd, pack_ctrl(1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
		compare_range(600, 200);
		// Zero length never starts
		bus_write(REG_LEN, '0, 4'b0011);
		bus_write(REG_CTRL, pack_ctrl(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), 4'b1111);
		wait_irq(20, seen);
		if (seen)
		begin
			$display("zero length start raised the interrupt");
			err_count++;
		end
		bus_read(REG_CTRL, rd);
		check_word("o_data CTRL", rd, '0);
		end_test("abort and zero length");

		// 6: interrupt clear without a start
		run_copy(int'($urandom % 1000), int'($urandom % 1000), 8, 1'b0, 1'b0);
		bus_write(REG_CTRL, pack_ctrl(1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 4'b1000);
		check_word("o_interrupt", word_t'(o_interrupt), '0);
		bus_read(REG_CTRL, rd);
		check_word("o_data CTRL", rd, '0);
		end_test("interrupt clear");

		$display("tests %0d, passed %0d, failed %0d, errors %0d", test_count,
			test_count - fail_count, fail_count, err_count);
		if (fail_count == 0 && err_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- all.f
verilog/dma_pkg.sv
verilog/dma_ctrl_if.sv
verilog/dma_regs.sv
verilog/dma_mover.sv
verilog/dma_sram.sv
verilog/dma_top.sv
bench/dma_tb.sv

//--- Makefile
# Verilator build and run for the DMA testbench

VERILATOR ?= verilator
TOP ?= dma_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
